// ==== tests/cr_dct_stim.txt ====
# name and pixel count, then eight rows of pixels as hex words, column 0 in the top byte
# then 64 expected coefficients at index u*8+k, vertical frequency u, horizontal k
flat128 64
8080808080808080 8080808080808080 8080808080808080 8080808080808080
8080808080808080 8080808080808080 8080808080808080 8080808080808080
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
flat200 64
c8c8c8c8c8c8c8c8 c8c8c8c8c8c8c8c8 c8c8c8c8c8c8c8c8 c8c8c8c8c8c8c8c8
c8c8c8c8c8c8c8c8 c8c8c8c8c8c8c8c8 c8c8c8c8c8c8c8c8 c8c8c8c8c8c8c8c8
577 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
flat0 64
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
-1024 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
vedge 64
00000000ffffffff 00000000ffffffff 00000000ffffffff 00000000ffffffff
00000000ffffffff 00000000ffffffff 00000000ffffffff 00000000ffffffff
-3 -925 0 325 0 -218 0 184 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
b2b_hedge 64
0000000000000000 0000000000000000 0000000000000000 0000000000000000
ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff
-4 0 0 0 0 0 0 0 -924 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 324 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 -217 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 184 0 0 0 0 0 0 0
abort 20
123456789abcdef0 0fedcba987654321 ff00ff00ff00ff00 00ff00ff00ff00ff
8080808080808080 8080808080808080 8080808080808080 8080808080808080
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
flat255 64
ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff
ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff
1015 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== list.f ====
+incdir+design
design/dct_types_pkg.sv
design/dct_cosine_pkg.sv
design/dct_sequencer.sv
design/dct_row_lane.sv
design/dct_column_stage.sv
design/cr_dct_top.sv
tests/cr_dct_properties.sv
tests/cr_dct_checker.sv
tests/cr_dct_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the DCT testbench with Verilator, runs it and checks the log
rm -rf obj_dir build.log sim.log
verilator --binary --assert -j 0 --top-module cr_dct_tb -f list.f -o cr_dct_sim \
	> build.log 2>&1 &&
	./obj_dir/cr_dct_sim > sim.log 2>&1 &&
	! grep -q "Simulation failed" sim.log &&
	echo "PASS" ||
	{ echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== tests/cr_dct_tb.sv ====
// Testbench for the 8x8 Cr DCT.
// Reads the blocks and their expected coefficients from the stim file, drives
// the pixels one per cycle with short random gaps, and hands each expected block
// to the checker. Ends with the test counts and the overall verdict.

`include "dct_settings.svh"

module cr_dct_tb
	import dct_types_pkg::*;
();

	localparam int max_tests = 16;
	localparam int block = `DCT_N * `DCT_N;

	logic clk;
	logic rst;
	logic enable;
	pixel_t data_in;
	coef_t coef_out [block];
	logic output_enable;

	logic exp_push;
	logic exp_full;
	logic [127:0] exp_name;
	coef_t exp_coef [block];
	int tests_done;
	int tests_failed;
	int errors;

	logic [127:0] names [max_tests];
	int counts [max_tests];
	pixel_t pixels [max_tests][block];
	coef_t expected [max_tests][block];
	int ntests;
	int cycles = 0;

	cr_dct_top u_cr_dct_top (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.data_in       (data_in),
		.coef_out      (coef_out),
		.output_enable (output_enable)
	);

	cr_dct_checker u_checker (
		.clk           (clk),
		.rst           (rst),
		.output_enable (output_enable),
		.coef_out      (coef_out),
		.exp_push      (exp_push),
		.exp_full      (exp_full),
		.exp_name      (exp_name),
		.exp_coef      (exp_coef),
		.tests_done    (tests_done),
		.tests_failed  (tests_failed),
		.errors        (errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	// Text read by %s is right aligned, so move its first character to the top byte
	function automatic logic [127:0] leading_text(logic [127:0] text);
		logic [127:0] shifted;
		shifted = text;
		for (int i = 0; i < 16; i++) begin
			if (shifted[127:120] == 8'h00)
				shifted = shifted << 8;
		end
		return shifted;
	endfunction

	task automatic read_stim(output logic ok);
		int fd;
		int got;
		int value;
		logic [127:0] tok;
		logic [127:0] lead;
		logic [63:0] word;
		logic [8*256-1:0] rest;
		ok = 1'b1;
		ntests = 0;
		fd = $fopen("tests/cr_dct_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/cr_dct_stim.txt");
			ok = 1'b0;
			return;
		end
		while (ntests < max_tests && $fscanf(fd, "%s", tok) == 1) begin
			lead = leading_text(tok);
			if (lead[127:120] == "#") begin
				got = $fgets(rest, fd);
				continue;
			end
			names[ntests] = tok;
			got = $fscanf(fd, "%d", counts[ntests]);
			// Each row is one hex word with column 0 in the top byte
			for (int r = 0; r < `DCT_N; r++) begin
				got += $fscanf(fd, "%h", word);
				for (int c = 0; c < `DCT_N; c++)
					pixels[ntests][r * `DCT_N + c] = word[63 - 8 * c -: 8];
			end
			for (int i = 0; i < block; i++) begin
				got += $fscanf(fd, "%d", value);
				expected[ntests][i] = coef_t'(value);
			end
			if (got != 1 + `DCT_N + block || counts[ntests] < 1 || counts[ntests] > block) begin
				$display("stim record %0d (%0s) is incomplete or malformed", ntests, tok);
				ok = 1'b0;
				break;
			end
			ntests++;
		end
		$fclose(fd);
	endtask

	task automatic idle_cycles(int n);
		enable = 1'b0;
		data_in = '0;
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// The expected block goes to the checker with the last pixel
	task automatic drive_block(int t);
		for (int i = 0; i < counts[t]; i++) begin
			enable = 1'b1;
			data_in = pixels[t][i];
			if (i == counts[t] - 1) begin
				exp_push = 1'b1;
				exp_full = (counts[t] == block);
				exp_name = names[t];
				for (int j = 0; j < block; j++)
					exp_coef[j] = expected[t][j];
			end
			@(posedge clk);
			#1;
			exp_push = 1'b0;
		end
	endtask

	initial begin
		logic stim_ok;
		logic timed_out;
		logic [127:0] lead;
		int gap;
		int limit;
		rst = 1'b1;
		enable = 1'b0;
		data_in = '0;
		exp_push = 1'b0;
		exp_full = 1'b0;
		exp_name = '0;
		for (int i = 0; i < block; i++)
			exp_coef[i] = '0;
		timed_out = 1'b0;
		void'($urandom(32'h5e6112b3));
		read_stim(stim_ok);

		limit = 0;
		for (int t = 0; t < ntests; t++)
			limit += counts[t] + 20;

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		if (stim_ok) begin
			for (int t = 0; t < ntests; t++) begin
				gap = $urandom % 4;
				lead = leading_text(names[t]);
				if (lead[127:96] == "b2b_")
					gap = 0;
				// Enable has to drop once to discard an aborted block
				if (t > 0 && counts[t - 1] < block && gap == 0)
					gap = 1;
				idle_cycles(gap);
				drive_block(t);
			end
			idle_cycles(0);
			while (tests_done < ntests && cycles < limit) begin
				@(posedge clk);
				#1;
			end
			timed_out = (tests_done < ntests);
		end

		if (timed_out)
			$display("timeout after %0d cycles with %0d of %0d tests finished",
				cycles, tests_done, ntests);
		$display("tests %0d of %0d done, %0d failed, %0d errors",
			tests_done, ntests, tests_failed, errors);
		if (stim_ok && !timed_out && ntests > 0 && errors == 0 && tests_failed == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tests/cr_dct_checker.sv ====
// Scoreboard for the DCT testbench.
// The testbench pushes one record per block together with its last pixel. The
// record falls due 7 cycles later, when output_enable must pulse for a full
// block and stay low for an aborted one. coef_out may change only with a pulse.

`include "dct_settings.svh"

module cr_dct_checker
	import dct_types_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         output_enable,
	input  coef_t        coef_out [`DCT_N*`DCT_N],
	input  logic         exp_push,
	input  logic         exp_full,
	input  logic [127:0] exp_name,
	input  coef_t        exp_coef [`DCT_N*`DCT_N],
	output int           tests_done,
	output int           tests_failed,
	output int           errors
);

	localparam int block = `DCT_N * `DCT_N;
	localparam int latency = 7;
	localparam int depth = 4;

	int cycle;
	int rd_ptr;
	int wr_ptr;
	int pending;
	int due [depth];
	logic full [depth];
	logic [127:0] name [depth];
	coef_t want [depth][block];
	coef_t held [block];

	always @(posedge clk) begin
		int test_errors;
		if (rst) begin
			cycle = 0;
			rd_ptr = 0;
			wr_ptr = 0;
			pending = 0;
			tests_done = 0;
			tests_failed = 0;
			errors = 0;
			for (int i = 0; i < block; i++)
				held[i] = '0;
		end else begin
			cycle++;
			if (exp_push) begin
				if (pending == depth) begin
					$display("record queue full, test %0s was dropped", exp_name);
					errors++;
				end else begin
					due[wr_ptr] = cycle + latency;
					full[wr_ptr] = exp_full;
					name[wr_ptr] = exp_name;
					for (int i = 0; i < block; i++)
						want[wr_ptr][i] = exp_coef[i];
					wr_ptr = (wr_ptr + 1) % depth;
					pending++;
				end
			end

			if (pending > 0 && due[rd_ptr] == cycle) begin
				test_errors = 0;
				if (full[rd_ptr] && !output_enable) begin
					$display("no output_enable for test %0s", name[rd_ptr]);
					test_errors++;
				end else if (!full[rd_ptr] && output_enable) begin
					$display("output_enable after aborted test %0s", name[rd_ptr]);
					test_errors++;
				end else if (full[rd_ptr]) begin
					for (int i = 0; i < block; i++) begin
						if (coef_out[i] !== want[rd_ptr][i]) begin
							$display("mismatch test %0s coef[%0d] expected %0d actual %0d",
								name[rd_ptr], i, want[rd_ptr][i], coef_out[i]);
							test_errors++;
						end
					end
				end
				if (test_errors == 0) begin
					$display("test %0s ok", name[rd_ptr]);
				end else begin
					$display("test %0s failed with %0d errors", name[rd_ptr], test_errors);
					tests_failed++;
				end
				errors += test_errors;
				tests_done++;
				rd_ptr = (rd_ptr + 1) % depth;
				pending--;
			end else if (output_enable) begin
				$display("output_enable at cycle %0d with no block due", cycle);
				errors++;
			end

			// Outside a pulse the last block must stay put
			for (int i = 0; i < block; i++) begin
				if (!output_enable && coef_out[i] !== held[i]) begin
					$display("coef_out[%0d] changed while output_enable was low", i);
					errors++;
				end
				held[i] = coef_out[i];
			end
		end
	end

endmodule

// ==== tests/cr_dct_properties.sv ====
// Timing assertions on the strobes of the DCT sequencer, attached with bind.
// row_done is a single-cycle pulse, block_last only comes with it, and
// every row end reaches row_done three cycles later.

module cr_dct_properties (
	input logic clk,
	input logic rst,
	input logic row_last,
	input logic row_done,
	input logic block_last
);

	single_row_done: assert property (@(posedge clk) disable iff (rst)
		row_done |=> !row_done)
		else $error("row_done was high on two consecutive cycles");

	block_last_with_row_done: assert property (@(posedge clk) disable iff (rst)
		block_last |-> row_done)
		else $error("block_last was high without row_done");

	// Product, sum and rounding stages of the lanes sit between the two
	row_done_delay: assert property (@(posedge clk) disable iff (rst)
		row_last |-> ##3 row_done)
		else $error("row_done did not follow row_last by three cycles");

endmodule

bind dct_sequencer cr_dct_properties u_properties (
	.clk        (clk),
	.rst        (rst),
	.row_last   (row_last),
	.row_done   (row_done),
	.block_last (block_last)
);

// ==== design/cr_dct_top.sv ====
// Top level of the 8x8 DCT for the Cr component.
// Pixels enter one per cycle while enable is high, row by row. All 64
// coefficients appear together on coef_out, index u*8+k, with a one-cycle
// output_enable pulse. coef_out holds until the next block completes.

`include "dct_settings.svh"

module cr_dct_top
	import dct_types_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   enable,
	input  pixel_t data_in,
	output coef_t  coef_out [`DCT_N*`DCT_N],
	output logic   output_enable
);

	pixel_t pixel;
	idx_t col;
	logic pixel_valid;
	logic row_last;
	logic row_done;
	idx_t row_idx;
	logic block_last;
	coef_t row_coef [`DCT_N];

	dct_sequencer u_sequencer (
		.clk         (clk),
		.rst         (rst),
		.enable      (enable),
		.data_in     (data_in),
		.pixel       (pixel),
		.col         (col),
		.pixel_valid (pixel_valid),
		.row_last    (row_last),
		.row_done    (row_done),
		.row_idx     (row_idx),
		.block_last  (block_last)
	);

	// One lane per horizontal frequency
	for (genvar i = 0; i < `DCT_N; i++) begin : g_lane
		dct_row_lane #(
			.freq (i)
		) u_lane (
			.clk         (clk),
			.rst         (rst),
			.pixel       (pixel),
			.col         (col),
			.pixel_valid (pixel_valid),
			.row_last    (row_last),
			.row_coef    (row_coef[i])
		);
	end

	dct_column_stage u_column_stage (
		.clk           (clk),
		.rst           (rst),
		.row_coef      (row_coef),
		.row_done      (row_done),
		.row_idx       (row_idx),
		.block_last    (block_last),
		.coef_out      (coef_out),
		.output_enable (output_enable)
	);

endmodule

// ==== design/dct_column_stage.sv ====
// Column transform of the DCT.
// Each row_done brings eight row coefficients, one per horizontal frequency.
// Every coefficient is weighted by the cosine of each vertical frequency at the
// current row and summed into 64 accumulators that restart at row 0. After row 7
// the sums are rounded into coef_out and output_enable pulses for one cycle.

`include "dct_settings.svh"

module dct_column_stage
	import dct_types_pkg::*;
	import dct_cosine_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  coef_t row_coef [`DCT_N],
	input  logic  row_done,
	input  idx_t  row_idx,
	input  logic  block_last,
	output coef_t coef_out [`DCT_N*`DCT_N],
	output logic  output_enable
);

	// Both arrays are indexed by vertical then horizontal frequency
	acc_t prod [`DCT_N][`DCT_N];
	acc_t acc [`DCT_N][`DCT_N];

	logic prod_valid;
	logic prod_first;
	logic prod_last;
	logic acc_last;

	always_ff @(posedge clk) begin
		if (row_done) begin
			for (int u = 0; u < `DCT_N; u++) begin
				for (int k = 0; k < `DCT_N; k++) begin
					prod[u][k] <= acc_t'(row_coef[k]) * acc_t'(dct_cos[u][row_idx]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int u = 0; u < `DCT_N; u++) begin
				for (int k = 0; k < `DCT_N; k++) begin
					acc[u][k] <= prod_first ? prod[u][k] : acc[u][k] + prod[u][k];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			prod_last <= 1'b0;
			acc_last <= 1'b0;
		end else begin
			prod_valid <= row_done;
			prod_first <= row_done && (row_idx == '0);
			prod_last <= row_done && block_last;
			acc_last <= prod_valid && prod_last;
		end
	end

	// coef_out keeps the last finished block until the next one is rounded
	always_ff @(posedge clk) begin
		if (rst) begin
			output_enable <= 1'b0;
			for (int i = 0; i < `DCT_N * `DCT_N; i++) begin
				coef_out[i] <= '0;
			end
		end else begin
			output_enable <= acc_last;
			if (acc_last) begin
				for (int u = 0; u < `DCT_N; u++) begin
					for (int k = 0; k < `DCT_N; k++) begin
						coef_out[u * `DCT_N + k] <= round_coef(acc[u][k]);
					end
				end
			end
		end
	end

endmodule

// ==== design/dct_row_lane.sv ====
// One horizontal frequency of the row transform.
// Each pixel is multiplied by the cosine entry for this frequency and its
// column, the eight products of a row are summed from a cleared start, and the
// sum is rounded into row_coef, which holds until the next row ends.

`include "dct_settings.svh"

module dct_row_lane
	import dct_types_pkg::*;
	import dct_cosine_pkg::*;
#(
	parameter int freq = 0
) (
	input  logic   clk,
	input  logic   rst,
	input  pixel_t pixel,
	input  idx_t   col,
	input  logic   pixel_valid,
	input  logic   row_last,
	output coef_t  row_coef
);

	// Only the DC lane carries the level shift
	localparam acc_t offset = (freq == 0) ? acc_t'(`DCT_DC_OFFSET) : acc_t'(0);

	acc_t prod;
	acc_t acc;
	logic prod_valid;
	logic prod_first;
	logic prod_last;
	logic acc_done;

	always_ff @(posedge clk) begin
		if (pixel_valid)
			prod <= acc_t'($signed({1'b0, pixel})) * acc_t'(dct_cos[freq][col]);
		if (prod_valid)
			acc <= prod_first ? prod : acc + prod;
		if (acc_done)
			row_coef <= round_coef(acc - offset);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			prod_last <= 1'b0;
			acc_done <= 1'b0;
		end else begin
			prod_valid <= pixel_valid;
			prod_first <= pixel_valid && (col == '0);
			prod_last <= pixel_valid && row_last;
			acc_done <= prod_valid && prod_last;
		end
	end

endmodule

// ==== design/dct_sequencer.sv ====
// Input sequencing for the DCT.
// Counts the column and row of each incoming pixel, registers the pixel for the
// row lanes and flags the last pixel of each row. The row-end flag is delayed
// so that row_done lines up with the rounded lane results.

`include "dct_settings.svh"

module dct_sequencer
	import dct_types_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   enable,
	input  pixel_t data_in,
	output pixel_t pixel,
	output idx_t   col,
	output logic   pixel_valid,
	output logic   row_last,
	output logic   row_done,
	output idx_t   row_idx,
	output logic   block_last
);

	localparam idx_t last_idx = idx_t'(`DCT_N - 1);

	idx_t col_cnt;
	idx_t row_cnt;
	idx_t last_row;
	logic [1:0] done_pipe;
	idx_t idx_pipe [2];

	// A drop of enable discards the partial block
	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else begin
			col_cnt <= col_cnt + idx_t'(1);
			if (col_cnt == last_idx)
				row_cnt <= row_cnt + idx_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		pixel <= data_in;
		col <= col_cnt;
		last_row <= row_cnt;
		idx_pipe[0] <= last_row;
		idx_pipe[1] <= idx_pipe[0];
		row_idx <= idx_pipe[1];
	end

	// Two stages for the lane product and sum, then the rounding edge
	always_ff @(posedge clk) begin
		if (rst) begin
			pixel_valid <= 1'b0;
			row_last <= 1'b0;
			done_pipe <= '0;
			row_done <= 1'b0;
			block_last <= 1'b0;
		end else begin
			pixel_valid <= enable;
			row_last <= enable && (col_cnt == last_idx);
			done_pipe <= {done_pipe[0], row_last};
			row_done <= done_pipe[1];
			block_last <= done_pipe[1] && (idx_pipe[1] == last_idx);
		end
	end

endmodule

// ==== design/dct_cosine_pkg.sv ====
// Cosine basis of the 8-point DCT at 2^14 scale.
// Indexed by frequency first and sample position second, so that
// dct_cos[u][x] = C(u) * cos((2x + 1) * u * pi / 16) * 16384.

`include "dct_settings.svh"

package dct_cosine_pkg;

	import dct_types_pkg::*;

	localparam cos_t dct_cos [`DCT_N][`DCT_N] = '{
		'{ 5793,  5793,  5793,  5793,  5793,  5793,  5793,  5793},
		'{ 8035,  6811,  4551,  1598, -1598, -4551, -6811, -8035},
		'{ 7568,  3135, -3135, -7568, -7568, -3135,  3135,  7568},
		'{ 6811, -1598, -8035, -4551,  4551,  8035,  1598, -6811},
		'{ 5793, -5793, -5793,  5793,  5793, -5793, -5793,  5793},
		'{ 4551, -8035,  1598,  6811, -6811, -1598,  8035, -4551},
		'{ 3135, -7568,  7568, -3135, -3135,  7568, -7568,  3135},
		'{ 1598, -4551,  6811, -8035,  8035, -6811,  4551, -1598}
	};

endpackage

// ==== design/dct_types_pkg.sv ====
// Data types of the DCT datapath and the common rounding step.
// Row lanes and the column stage round their sums the same way.

`include "dct_settings.svh"

package dct_types_pkg;

	typedef logic [`DCT_PIXEL_W-1:0] pixel_t;
	typedef logic signed [`DCT_COEF_W-1:0] coef_t;
	typedef logic signed [`DCT_COS_W-1:0] cos_t;
	typedef logic signed [`DCT_ACC_W-1:0] acc_t;
	typedef logic [$clog2(`DCT_N)-1:0] idx_t;

	// Keep the bits above the fraction and add one when the top fraction bit is set
	function automatic coef_t round_coef(acc_t sum);
		logic [`DCT_COEF_W-1:0] kept;
		kept = sum[`DCT_FRAC_W +: `DCT_COEF_W];
		return coef_t'(kept + {{(`DCT_COEF_W-1){1'b0}}, sum[`DCT_FRAC_W-1]});
	endfunction

endpackage

// ==== design/dct_settings.svh ====
// Sizes and fixed-point constants shared by the 8x8 chroma DCT.
// Include this header before any package or module that uses the macros.
// The DC offset replaces the per-pixel level shift of 128.

`ifndef DCT_SETTINGS_SVH
`define DCT_SETTINGS_SVH

// Side length of a block; the block holds DCT_N * DCT_N pixels
`define DCT_N 8

// Unsigned input pixel
`define DCT_PIXEL_W 8

// Signed rounded output coefficient
`define DCT_COEF_W 11

// Signed cosine entry scaled by 2^14
`define DCT_COS_W 16

// Fraction bits dropped when a sum is rounded
`define DCT_FRAC_W 14

// Products and running sums
`define DCT_ACC_W 32

// Level-shift correction for the DC lane, equal to 128 * 8 * 5793
`define DCT_DC_OFFSET 32'sd5932032

`endif
